//--- src/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// ==========================================================
	// Bus field types
	// ==========================================================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  region_t;
	typedef logic [3:0]  slot_t;
	typedef logic [1:0]  master_id_t;
	typedef logic [9:0]  led_t;

	// Requestor identities
	localparam master_id_t MASTER_NONE = 2'd0;
	localparam master_id_t MASTER_IBUS = 2'd1;
	localparam master_id_t MASTER_DBUS = 2'd2;
	localparam master_id_t MASTER_DMA  = 2'd3;

	// ==========================================================
	// Address map
	// ==========================================================

	localparam region_t REGION_ROM    = 4'h0;
	localparam region_t REGION_RAM    = 4'h2;
	localparam region_t REGION_BRIDGE = 4'h5;

	localparam slot_t SLOT_SYSREG = 4'h9;

	localparam int ROM_WORDS = 16;

	// ==========================================================
	// Bus structs and arbiter state
	// ==========================================================

	typedef struct packed {
		logic  request;
		logic  rw;
		addr_t address;
		data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic  ready;
		data_t rdata;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY,
		ARB_DONE
	} arb_state_e;

endpackage

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic                i_clock,
	input  logic                i_rst_n,

	input  soc_pkg::bus_req_t   i_ibus,
	input  soc_pkg::bus_req_t   i_dbus,
	input  soc_pkg::bus_req_t   i_dma,
	output soc_pkg::bus_rsp_t   o_ibus,
	output soc_pkg::bus_rsp_t   o_dbus,
	output soc_pkg::bus_rsp_t   o_dma,

	output soc_pkg::bus_req_t   o_bus,
	input  soc_pkg::bus_rsp_t   i_bus,
	output soc_pkg::master_id_t o_grant
);
	import soc_pkg::*;

	arb_state_e state;
	master_id_t grant;
	master_id_t pick;
	bus_req_t   pick_req;
	logic       bus_rw;
	addr_t      bus_address;
	data_t      bus_wdata;
	data_t      rsp_rdata;
	logic       done;

	// Data port first, then instruction, then DMA
	always_comb begin
		pick = MASTER_NONE;
		pick_req = i_dma;
		if (i_dbus.request) begin
			pick = MASTER_DBUS;
			pick_req = i_dbus;
		end else if (i_ibus.request) begin
			pick = MASTER_IBUS;
			pick_req = i_ibus;
			// Fetches are always reads
			pick_req.rw = 1'b0;
		end else if (i_dma.request) begin
			pick = MASTER_DMA;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ARB_IDLE;
			grant <= MASTER_NONE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick != MASTER_NONE) begin
						state <= ARB_BUSY;
						grant <= pick;
					end
				end
				ARB_BUSY: begin
					if (i_bus.ready)
						state <= ARB_DONE;
				end
				ARB_DONE: begin
					state <= ARB_IDLE;
					grant <= MASTER_NONE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE && pick != MASTER_NONE) begin
			bus_rw <= pick_req.rw;
			bus_address <= pick_req.address;
			bus_wdata <= pick_req.wdata;
		end
		if (state == ARB_BUSY && i_bus.ready)
			rsp_rdata <= i_bus.rdata;
	end

	// Bus request is high for the whole busy state
	assign o_bus = '{request: (state == ARB_BUSY), rw: bus_rw,
		address: bus_address, wdata: bus_wdata};

	assign done = (state == ARB_DONE);
	assign o_ibus = '{ready: done && grant == MASTER_IBUS, rdata: rsp_rdata};
	assign o_dbus = '{ready: done && grant == MASTER_DBUS, rdata: rsp_rdata};
	assign o_dma = '{ready: done && grant == MASTER_DMA, rdata: rsp_rdata};
	assign o_grant = grant;

endmodule

`default_nettype wire

//--- src/region_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
	input  soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,

	output soc_pkg::bus_req_t o_rom,
	output soc_pkg::bus_req_t o_ram,
	output soc_pkg::bus_req_t o_bridge,
	input  soc_pkg::bus_rsp_t i_rom,
	input  soc_pkg::bus_rsp_t i_ram,
	input  soc_pkg::bus_rsp_t i_bridge,

	output logic              o_fault_strobe,
	output soc_pkg::addr_t    o_fault_address
);
	import soc_pkg::*;

	region_t region;
	addr_t   local_address;
	logic    sel_rom;
	logic    sel_ram;
	logic    sel_bridge;
	logic    unmapped;

	assign region = i_bus.address[31:28];
	assign local_address = {4'h0, i_bus.address[27:0]};

	assign sel_rom = (region == REGION_ROM);
	assign sel_ram = (region == REGION_RAM);
	assign sel_bridge = (region == REGION_BRIDGE);
	assign unmapped = !(sel_rom || sel_ram || sel_bridge);

	assign o_rom = '{request: i_bus.request && sel_rom, rw: i_bus.rw,
		address: local_address, wdata: i_bus.wdata};
	assign o_ram = '{request: i_bus.request && sel_ram, rw: i_bus.rw,
		address: local_address, wdata: i_bus.wdata};
	assign o_bridge = '{request: i_bus.request && sel_bridge, rw: i_bus.rw,
		address: local_address, wdata: i_bus.wdata};

	// Unmapped accesses finish right away and read zero
	always_comb begin
		if (sel_rom)
			o_bus = i_rom;
		else if (sel_ram)
			o_bus = i_ram;
		else if (sel_bridge)
			o_bus = i_bridge;
		else
			o_bus = '{ready: i_bus.request, rdata: '0};
	end

	assign o_fault_strobe = i_bus.request && unmapped;
	assign o_fault_address = i_bus.address;

endmodule

`default_nettype wire

//--- src/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
	input  logic              i_clock,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);
	import soc_pkg::*;

	data_t      rom [ROM_WORDS];
	logic [3:0] index;
	logic       ready_q;
	data_t      rdata_q;

	initial $readmemh("rom_init.hex", rom);

	assign index = i_req.address[5:2];

	// Writes are answered like reads and leave the contents alone
	always_ff @(posedge i_clock) begin
		ready_q <= i_req.request && !ready_q;
		rdata_q <= rom[index];
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- src/latency_ram.sv
`timescale 1ns/1ps
`default_nettype none

module latency_ram #(
	parameter int RAM_WORDS   = 1024,
	parameter int RAM_LATENCY = 16
) (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);
	import soc_pkg::*;

	localparam int INDEX_BITS = $clog2(RAM_WORDS);
	localparam int COUNT_BITS = $clog2(RAM_LATENCY + 1);

	data_t                  mem [RAM_WORDS];
	logic [INDEX_BITS-1:0]  index;
	logic [COUNT_BITS-1:0]  count;
	logic                   ready_q;
	logic                   finish;
	data_t                  rdata_q;

	// Power of two size, so the low word bits wrap the address
	assign index = i_req.address[INDEX_BITS+1:2];
	assign finish = (count == COUNT_BITS'(1));

	// Count down from first sight of the request
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= finish;
			if (finish)
				count <= '0;
			else if (count != '0)
				count <= count - 1'b1;
			else if (i_req.request && !ready_q)
				count <= COUNT_BITS'(RAM_LATENCY - 1);
		end
	end

	// Access happens on the edge that raises ready
	always_ff @(posedge i_clock) begin
		if (finish) begin
			rdata_q <= mem[index];
			if (i_req.rw)
				mem[index] <= i_req.wdata;
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- src/io_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_near,
	output soc_pkg::bus_rsp_t o_near,
	output soc_pkg::bus_req_t o_far,
	input  soc_pkg::bus_rsp_t i_far
);
	import soc_pkg::*;

	logic  far_request;
	logic  far_rw;
	addr_t far_address;
	data_t far_wdata;
	slot_t far_slot;
	logic  slot_hit;
	logic  empty_ready;

	assign far_slot = far_address[27:24];
	assign slot_hit = (far_slot == SLOT_SYSREG);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			far_request <= 1'b0;
			empty_ready <= 1'b0;
		end else begin
			if (o_near.ready)
				far_request <= 1'b0;
			else if (i_near.request)
				far_request <= 1'b1;
			// Nobody lives in this slot, answer for it
			empty_ready <= far_request && !slot_hit && !empty_ready;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_near.request && !far_request) begin
			far_rw <= i_near.rw;
			far_address <= i_near.address;
			far_wdata <= i_near.wdata;
		end
	end

	assign o_far = '{request: far_request && slot_hit, rw: far_rw,
		address: far_address, wdata: far_wdata};

	assign o_near = '{ready: slot_hit ? i_far.ready : empty_ready,
		rdata: slot_hit ? i_far.rdata : '0};

endmodule

`default_nettype wire

//--- src/system_registers.sv
`timescale 1ns/1ps
`default_nettype none

module system_registers #(
	parameter soc_pkg::data_t DEVICE_ID = 32'd1,
	parameter int             RAM_WORDS = 1024
) (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,
	input  logic              i_boot_mode,
	output soc_pkg::led_t     o_leds
);
	import soc_pkg::*;

	localparam logic [2:0] REG_DEVICE_ID = 3'd0;
	localparam logic [2:0] REG_RAM_SIZE  = 3'd1;
	localparam logic [2:0] REG_LEDS      = 3'd2;
	localparam logic [2:0] REG_BOOT_MODE = 3'd3;

	logic [2:0] index;
	logic       access;
	logic       ready_q;
	led_t       leds_q;
	data_t      read_value;
	data_t      rdata_q;

	assign index = i_req.address[4:2];
	assign access = i_req.request && !ready_q;

	always_comb begin
		case (index)
			REG_DEVICE_ID: read_value = DEVICE_ID;
			REG_RAM_SIZE:  read_value = data_t'(RAM_WORDS * 4);
			REG_LEDS:      read_value = {22'd0, leds_q};
			REG_BOOT_MODE: read_value = {31'd0, i_boot_mode};
			default:       read_value = '0;
		endcase
	end

	// Only the LED register takes writes
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			leds_q <= '0;
		end else begin
			ready_q <= access;
			if (access && i_req.rw && index == REG_LEDS)
				leds_q <= i_req.wdata[9:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (access)
			rdata_q <= read_value;
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};
	assign o_leds = leds_q;

endmodule

`default_nettype wire

//--- src/bus_fault_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fault_monitor (
	input  logic                i_clock,
	input  logic                i_rst_n,
	input  logic                i_fault_strobe,
	input  soc_pkg::addr_t      i_fault_address,
	input  soc_pkg::master_id_t i_grant,
	output logic                o_fault,
	output soc_pkg::addr_t      o_fault_address,
	output soc_pkg::master_id_t o_fault_source
);
	import soc_pkg::*;

	// Sticky, the first fault wins
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_fault <= 1'b0;
			o_fault_address <= '0;
			o_fault_source <= MASTER_NONE;
		end else if (i_fault_strobe && !o_fault) begin
			o_fault <= 1'b1;
			o_fault_address <= i_fault_address;
			o_fault_source <= i_grant;
		end
	end

endmodule

`default_nettype wire

//--- src/soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric #(
	parameter int             RAM_WORDS   = 1024,
	parameter int             RAM_LATENCY = 16,
	parameter soc_pkg::data_t DEVICE_ID   = 32'd1
) (
	input  logic                i_clock,
	input  logic                i_rst_n,

	input  soc_pkg::bus_req_t   i_ibus,
	output soc_pkg::bus_rsp_t   o_ibus,
	input  soc_pkg::bus_req_t   i_dbus,
	output soc_pkg::bus_rsp_t   o_dbus,
	input  soc_pkg::bus_req_t   i_dma,
	output soc_pkg::bus_rsp_t   o_dma,

	input  logic                i_boot_mode,
	output soc_pkg::led_t       o_leds,

	output logic                o_fault,
	output soc_pkg::addr_t      o_fault_address,
	output soc_pkg::master_id_t o_fault_source
);
	import soc_pkg::*;

	bus_req_t   bus_req;
	bus_rsp_t   bus_rsp;
	master_id_t grant;

	bus_req_t   rom_req;
	bus_rsp_t   rom_rsp;
	bus_req_t   ram_req;
	bus_rsp_t   ram_rsp;
	bus_req_t   bridge_req;
	bus_rsp_t   bridge_rsp;
	bus_req_t   sysreg_req;
	bus_rsp_t   sysreg_rsp;

	logic       fault_strobe;
	addr_t      fault_address;

	// ==========================================================
	// Shared bus
	// ==========================================================

	bus_arbiter arbiter0 (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_ibus  (i_ibus),
		.i_dbus  (i_dbus),
		.i_dma   (i_dma),
		.o_ibus  (o_ibus),
		.o_dbus  (o_dbus),
		.o_dma   (o_dma),
		.o_bus   (bus_req),
		.i_bus   (bus_rsp),
		.o_grant (grant)
	);

	region_decoder decoder0 (
		.i_bus           (bus_req),
		.o_bus           (bus_rsp),
		.o_rom           (rom_req),
		.o_ram           (ram_req),
		.o_bridge        (bridge_req),
		.i_rom           (rom_rsp),
		.i_ram           (ram_rsp),
		.i_bridge        (bridge_rsp),
		.o_fault_strobe  (fault_strobe),
		.o_fault_address (fault_address)
	);

	// ==========================================================
	// Memories
	// ==========================================================

	boot_rom rom0 (
		.i_clock (i_clock),
		.i_req   (rom_req),
		.o_rsp   (rom_rsp)
	);

	latency_ram #(
		.RAM_WORDS   (RAM_WORDS),
		.RAM_LATENCY (RAM_LATENCY)
	) ram0 (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	// ==========================================================
	// I/O side
	// ==========================================================

	io_bridge bridge0 (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_near  (bridge_req),
		.o_near  (bridge_rsp),
		.o_far   (sysreg_req),
		.i_far   (sysreg_rsp)
	);

	system_registers #(
		.DEVICE_ID (DEVICE_ID),
		.RAM_WORDS (RAM_WORDS)
	) sysreg0 (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_req       (sysreg_req),
		.o_rsp       (sysreg_rsp),
		.i_boot_mode (i_boot_mode),
		.o_leds      (o_leds)
	);

	bus_fault_monitor fault0 (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_fault_strobe  (fault_strobe),
		.i_fault_address (fault_address),
		.i_grant         (grant),
		.o_fault         (o_fault),
		.o_fault_address (o_fault_address),
		.o_fault_source  (o_fault_source)
	);

endmodule

`default_nettype wire

//--- testbench/soc_fabric_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_asserts (
	input logic              i_clock,
	input logic              i_rst_n,
	input soc_pkg::bus_req_t i_ibus_req,
	input soc_pkg::bus_req_t i_dbus_req,
	input soc_pkg::bus_req_t i_dma_req,
	input soc_pkg::bus_rsp_t i_ibus_rsp,
	input soc_pkg::bus_rsp_t i_dbus_rsp,
	input soc_pkg::bus_rsp_t i_dma_rsp,
	input soc_pkg::bus_req_t i_bus_req,
	input soc_pkg::bus_rsp_t i_bus_rsp,
	input logic              i_fault
);

	// At most one port answered per cycle
	readies_one_hot: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$onehot0({i_ibus_rsp.ready, i_dbus_rsp.ready, i_dma_rsp.ready}))
		else $error("port readies are not one-hot or zero");

	// A port is only answered while it asks
	ibus_ready_follows: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ibus_rsp.ready |-> i_ibus_req.request)
		else $error("ibus ready without ibus request");
	dbus_ready_follows: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dbus_rsp.ready |-> i_dbus_req.request)
		else $error("dbus ready without dbus request");
	dma_ready_follows: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dma_rsp.ready |-> i_dma_req.request)
		else $error("dma ready without dma request");

	bus_request_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bus_req.request && !i_bus_rsp.ready |=> i_bus_req.request)
		else $error("bus request dropped before bus ready");

	// Sticky until reset
	fault_sticky: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_fault |=> i_fault)
		else $error("fault flag fell without reset");

endmodule

// Arbiter side, the fault flag does not exist here
bind bus_arbiter soc_fabric_asserts arbiter_asserts0 (
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_ibus_req (i_ibus),
	.i_dbus_req (i_dbus),
	.i_dma_req  (i_dma),
	.i_ibus_rsp (o_ibus),
	.i_dbus_rsp (o_dbus),
	.i_dma_rsp  (o_dma),
	.i_bus_req  (o_bus),
	.i_bus_rsp  (i_bus),
	.i_fault    (1'b0)
);

// Fault side, bus ports tied idle
bind bus_fault_monitor soc_fabric_asserts fault_asserts0 (
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_ibus_req ('0),
	.i_dbus_req ('0),
	.i_dma_req  ('0),
	.i_ibus_rsp ('0),
	.i_dbus_rsp ('0),
	.i_dma_rsp  ('0),
	.i_bus_req  ('0),
	.i_bus_rsp  ('0),
	.i_fault    (o_fault)
);

`default_nettype wire

//--- testbench/tb_soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric;
	import soc_pkg::*;

	localparam int    CLOCK_PERIOD = 10;
	localparam int    RAM_WORDS = 1024;
	localparam int    RAM_LATENCY = 16;
	localparam data_t DEVICE_ID = 32'd1;
	localparam int    RAM_OPS = 24;
	localparam int    ACCESS_COUNT = 3 * ROM_WORDS + 2 * RAM_OPS + 9 + 12 + 2;
	localparam int    READY_LIMIT = 4 * (RAM_LATENCY + 8);
	localparam int    WATCHDOG_CYCLES = ACCESS_COUNT * (RAM_LATENCY + 8) + 200;

	typedef struct packed {
		logic  check;
		data_t data;
	} expect_t;

	logic       clock;
	logic       rst_n;
	bus_req_t   ibus_req;
	bus_req_t   dbus_req;
	bus_req_t   dma_req;
	bus_rsp_t   ibus_rsp;
	bus_rsp_t   dbus_rsp;
	bus_rsp_t   dma_rsp;
	logic       boot_mode;
	led_t       leds;
	logic       fault;
	addr_t      fault_address;
	master_id_t fault_source;

	// Reference state
	data_t      rom_model [ROM_WORDS];
	data_t      shadow_ram [RAM_WORDS];
	led_t       led_shadow;
	logic [31:0] rng_state;

	expect_t    ibus_expect [$];
	expect_t    dbus_expect [$];
	expect_t    dma_expect [$];
	master_id_t ready_order [$];
	int         value_errors;
	int         protocol_errors;

	soc_fabric #(
		.RAM_WORDS   (RAM_WORDS),
		.RAM_LATENCY (RAM_LATENCY),
		.DEVICE_ID   (DEVICE_ID)
	) dut0 (
		.i_clock         (clock),
		.i_rst_n         (rst_n),
		.i_ibus          (ibus_req),
		.o_ibus          (ibus_rsp),
		.i_dbus          (dbus_req),
		.o_dbus          (dbus_rsp),
		.i_dma           (dma_req),
		.o_dma           (dma_rsp),
		.i_boot_mode     (boot_mode),
		.o_leds          (leds),
		.o_fault         (fault),
		.o_fault_address (fault_address),
		.o_fault_source  (fault_source)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// ==========================================================
	// Reference model
	// ==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic addr_t sysreg_address(input logic [2:0] index);
		return {REGION_BRIDGE, SLOT_SYSREG, 19'd0, index, 2'b00};
	endfunction

	function automatic data_t expected_read(input addr_t address);
		case (address[31:28])
			REGION_ROM: return rom_model[address[5:2]];
			REGION_RAM: return shadow_ram[int'(address[27:2]) % RAM_WORDS];
			REGION_BRIDGE: begin
				if (address[27:24] != SLOT_SYSREG)
					return '0;
				case (address[4:2])
					3'd0: return DEVICE_ID;
					3'd1: return data_t'(RAM_WORDS * 4);
					3'd2: return {22'd0, led_shadow};
					3'd3: return {31'd0, boot_mode};
					default: return '0;
				endcase
			end
			default: return '0;
		endcase
	endfunction

	function automatic void model_write(input addr_t address, input data_t wdata);
		if (address[31:28] == REGION_RAM)
			shadow_ram[int'(address[27:2]) % RAM_WORDS] = wdata;
		else if (address[31:28] == REGION_BRIDGE && address[27:24] == SLOT_SYSREG
				&& address[4:2] == 3'd2)
			led_shadow = wdata[9:0];
	endfunction

	function automatic string port_name(input master_id_t port);
		case (port)
			MASTER_IBUS: return "ibus";
			MASTER_DBUS: return "dbus";
			MASTER_DMA:  return "dma";
			default:     return "none";
		endcase
	endfunction

	// ==========================================================
	// Compare tasks
	// ==========================================================

	task automatic compare_data(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic compare_master(input string name, input master_id_t actual,
			input master_id_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic compare_leds(input string name, input led_t actual, input led_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	// ==========================================================
	// Port driving
	// ==========================================================

	function automatic logic port_ready(input master_id_t port);
		case (port)
			MASTER_IBUS: return ibus_rsp.ready;
			MASTER_DBUS: return dbus_rsp.ready;
			default:     return dma_rsp.ready;
		endcase
	endfunction

	task automatic drive_port(input master_id_t port, input bus_req_t req);
		case (port)
			MASTER_IBUS: ibus_req <= req;
			MASTER_DBUS: dbus_req <= req;
			default:     dma_req <= req;
		endcase
	endtask

	// One access, expected value queued before the request goes out
	task automatic access(input master_id_t port, input logic rw, input addr_t address,
			input data_t wdata);
		expect_t  expected;
		bus_req_t req;
		int       waited;
		expected.check = !rw;
		expected.data = expected_read(address);
		if (rw)
			model_write(address, wdata);
		case (port)
			MASTER_IBUS: ibus_expect.push_back(expected);
			MASTER_DBUS: dbus_expect.push_back(expected);
			default:     dma_expect.push_back(expected);
		endcase
		req.request = 1'b1;
		req.rw = rw;
		req.address = address;
		req.wdata = wdata;
		@(posedge clock);
		drive_port(port, req);
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!port_ready(port) && waited < READY_LIMIT);
		if (!port_ready(port)) begin
			$display("ERROR at %0t: %s port never got ready for address %h", $time,
				port_name(port), address);
			protocol_errors++;
		end
		@(posedge clock);
		drive_port(port, '0);
	endtask

	// ==========================================================
	// Response checking
	// ==========================================================

	task automatic check_ready(input master_id_t port, input data_t rdata);
		expect_t expected;
		logic    found;
		found = 1'b0;
		case (port)
			MASTER_IBUS: if (ibus_expect.size() > 0) begin
				expected = ibus_expect.pop_front();
				found = 1'b1;
			end
			MASTER_DBUS: if (dbus_expect.size() > 0) begin
				expected = dbus_expect.pop_front();
				found = 1'b1;
			end
			default: if (dma_expect.size() > 0) begin
				expected = dma_expect.pop_front();
				found = 1'b1;
			end
		endcase
		ready_order.push_back(port);
		if (!found) begin
			$display("ERROR at %0t: ready on %s port with no access pending", $time,
				port_name(port));
			protocol_errors++;
		end else if (expected.check) begin
			compare_data({"o_", port_name(port), ".rdata"}, rdata, expected.data);
		end
	endtask

	always @(negedge clock) begin
		if (rst_n) begin
			if (ibus_rsp.ready)
				check_ready(MASTER_IBUS, ibus_rsp.rdata);
			if (dbus_rsp.ready)
				check_ready(MASTER_DBUS, dbus_rsp.rdata);
			if (dma_rsp.ready)
				check_ready(MASTER_DMA, dma_rsp.rdata);
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	// ==========================================================
	// Stimulus
	// ==========================================================

	initial begin : main
		int         i;
		int         k;
		logic [31:0] r;
		addr_t      address;
		addr_t      written [$];
		master_id_t order [3];

		clock = 1'b0;
		rst_n = 1'b0;
		ibus_req = '0;
		dbus_req = '0;
		dma_req = '0;
		boot_mode = 1'b1;
		led_shadow = '0;
		rng_state = 32'hc192ea49;
		value_errors = 0;
		protocol_errors = 0;
		$readmemh("rom_init.hex", rom_model);

		@(negedge clock);
		if (ibus_rsp.ready || dbus_rsp.ready || dma_rsp.ready || fault || leds != '0) begin
			$display("ERROR: outputs active during reset");
			protocol_errors++;
		end
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);

		// ROM through every port
		for (k = 1; k <= 3; k++)
			for (i = 0; i < ROM_WORDS; i++)
				access(master_id_t'(k), 1'b0, {REGION_ROM, 22'd0, i[3:0], 2'b00}, '0);

		// Random RAM writes, aliased above RAM_WORDS
		for (i = 0; i < RAM_OPS; i++) begin
			r = next_random();
			address = {REGION_RAM, r[27:12], 5'd0, r[4:0], 2'b00};
			written.push_back(address);
			access((i % 2 == 0) ? MASTER_DBUS : MASTER_DMA, 1'b1, address, next_random());
		end
		for (i = 0; i < RAM_OPS; i++) begin
			r = next_random();
			address = {REGION_RAM, r[27:12], written[i][11:0]};
			access(master_id_t'(i % 3 + 1), 1'b0, address, '0);
		end

		// All three ports at once
		order[0] = MASTER_DBUS;
		order[1] = MASTER_IBUS;
		order[2] = MASTER_DMA;
		for (k = 0; k < 3; k++) begin
			ready_order.delete();
			fork
				access(MASTER_DMA, 1'b0, sysreg_address(k[2:0]), '0);
				access(MASTER_IBUS, 1'b0, {REGION_ROM, 22'd0, k[3:0], 2'b00}, '0);
				access(MASTER_DBUS, 1'b0, written[k], '0);
			join
			if (ready_order.size() != 3) begin
				$display("ERROR: %0d readies for 3 simultaneous requests", ready_order.size());
				protocol_errors++;
			end else begin
				for (i = 0; i < 3; i++)
					compare_master("ready order", ready_order[i], order[i]);
			end
		end

		// System registers and empty slot
		access(MASTER_DBUS, 1'b0, sysreg_address(3'd0), '0);
		access(MASTER_DMA, 1'b0, sysreg_address(3'd1), '0);
		access(MASTER_IBUS, 1'b0, sysreg_address(3'd3), '0);
		access(MASTER_DBUS, 1'b1, sysreg_address(3'd2), next_random());
		@(negedge clock);
		compare_leds("o_leds", leds, led_shadow);
		access(MASTER_DMA, 1'b0, sysreg_address(3'd2), '0);
		access(MASTER_DBUS, 1'b1, sysreg_address(3'd0), 32'hdeadbeef);
		access(MASTER_DBUS, 1'b0, sysreg_address(3'd0), '0);
		access(MASTER_DMA, 1'b1, sysreg_address(3'd1), 32'h12345678);
		access(MASTER_IBUS, 1'b0, sysreg_address(3'd1), '0);
		access(MASTER_DBUS, 1'b0, {REGION_BRIDGE, 4'h3, 24'h000004}, '0);
		access(MASTER_DMA, 1'b0, sysreg_address(3'd5), '0);
		@(posedge clock);
		boot_mode <= 1'b0;
		@(posedge clock);
		access(MASTER_DBUS, 1'b0, sysreg_address(3'd3), '0);
		@(negedge clock);
		if (fault) begin
			$display("ERROR: fault flag set before any unmapped access");
			protocol_errors++;
		end

		// Unmapped region, first fault kept
		access(MASTER_DMA, 1'b0, 32'h7000_1230, '0);
		@(negedge clock);
		if (!fault) begin
			$display("ERROR: fault flag did not rise after an unmapped access");
			protocol_errors++;
		end
		compare_addr("o_fault_address", fault_address, 32'h7000_1230);
		compare_master("o_fault_source", fault_source, MASTER_DMA);
		access(MASTER_DBUS, 1'b0, 32'h7abc_0040, '0);
		@(negedge clock);
		compare_addr("o_fault_address", fault_address, 32'h7000_1230);
		compare_master("o_fault_source", fault_source, MASTER_DMA);

		repeat (4) @(posedge clock);
		if (ibus_expect.size() + dbus_expect.size() + dma_expect.size() != 0) begin
			$display("ERROR: accesses left without a ready at the end of the run");
			protocol_errors++;
		end
		$display("Errors: %0d value mismatches, %0d protocol errors", value_errors,
			protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
src/soc_pkg.sv
src/bus_arbiter.sv
src/region_decoder.sv
src/boot_rom.sv
src/latency_ram.sv
src/io_bridge.sv
src/system_registers.sv
src/bus_fault_monitor.sv
src/soc_fabric.sv
testbench/soc_fabric_asserts.sv
testbench/tb_soc_fabric.sv

//--- Makefile
# Verilator simulation of the soc_fabric bus
TOP := tb_soc_fabric
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rom_init.hex
// One 32-bit word per line in hex, ROM word 0 first
00000297
02028293
30529073
00001117
ff010113
5a5a0001
c3c3f00d
13572468
9abcdef0
0f1e2d3c
4b5a6978
8796a5b4
c3d2e1f0
deadc0de
0badf00d
80000073
